// File: logic/sensio_pkg.sv
/* sensor i/o shared definitions */
package sensio_pkg;

    localparam logic [15:0] SENSIO_ADDR      = 16'h0330; // base of the sensor i/o block
    localparam logic [15:0] SENSIO_ADDR_MASK = 16'h07f8; // low 3 bits select the register

    localparam logic [2:0] SENSIO_CTRL  = 3'h0; // resets and aro
    localparam logic [2:0] SENSIO_JTAG  = 3'h2; // bit-banged jtag to the board fpga
    localparam logic [2:0] SENSIO_WIDTH = 3'h3; // line width, 0 keeps hact as is

    localparam int CMD_BYTES     = 6;                   // al, ah, d0..d3
    localparam int CMD_CNT_BITS  = $clog2(CMD_BYTES);
    localparam int CMD_ADDR_BITS = 3;
    localparam int CMD_DATA_BITS = 32;

    localparam int LINE_WIDTH_BITS = 16;

    // control register, lower bit of each pair of bits
    localparam int SENS_CTRL_MRST = 0; // 1:0
    localparam int SENS_CTRL_ARST = 2; // 3:2
    localparam int SENS_CTRL_ARO  = 4; // 5:4

    // jtag register
    localparam int SENS_JTAG_TDI   = 0; // 1:0
    localparam int SENS_JTAG_TMS   = 2; // 3:2
    localparam int SENS_JTAG_TCK   = 4; // 5:4
    localparam int SENS_JTAG_PROG  = 6; // 7:6
    localparam int SENS_JTAG_PGMEN = 8; // 9:8

    typedef struct packed {
        logic en;  // write enable for this field
        logic val; // new value
    } sens_pair_t;

    typedef struct packed {
        logic [CMD_DATA_BITS-SENS_CTRL_ARO-3:0] rsvd; // mmcm/quadrant bits, unused here
        sens_pair_t aro;
        sens_pair_t arst;
        sens_pair_t mrst;
    } sens_ctrl_view_t;

    typedef struct packed {
        logic [CMD_DATA_BITS-SENS_JTAG_PGMEN-3:0] rsvd;
        sens_pair_t pgmen;
        sens_pair_t prog;
        sens_pair_t tck;
        sens_pair_t tms;
        sens_pair_t tdi;
    } sens_jtag_view_t;

    typedef union packed {
        logic [CMD_DATA_BITS-1:0] raw;
        sens_ctrl_view_t          ctrl;
        sens_jtag_view_t          jtag;
    } sensio_data_u;

    // keep old value unless the field is enabled
    function automatic logic pair_next(logic cur, sens_pair_t p);
        return p.en ? p.val : cur;
    endfunction

endpackage

// File: logic/sens_ctrl_if.sv
/* sensor control bits */
`timescale 1ns/1ps

interface sens_ctrl_if;

    logic mrst;     // sensor master reset
    logic arst;     // aux reset, tms when programming
    logic aro_soft; // software aro level
    logic pgmen;    // board fpga programming mode
    logic prog;     // prog_b, sent inverted
    logic tck;
    logic tms;
    logic tdi;

    modport regs (
        output mrst, arst, aro_soft, pgmen, prog, tck, tms, tdi
    );

    modport pins (
        input mrst, arst, aro_soft, pgmen, prog, tck, tms, tdi
    );

endinterface

// File: logic/sensio_cmd_deser.sv
/* byte-serial command deserializer */
`timescale 1ns/1ps

module sensio_cmd_deser (
    input  logic                                  mclk,
    input  logic                                  mclk_rst,
    input  logic [7:0]                            cmd_ad_i,  // al, ah, d0..d3
    input  logic                                  cmd_stb_i, // with the al byte
    output logic                                  cmd_we_o,
    output logic [sensio_pkg::CMD_ADDR_BITS-1:0]  cmd_addr_o,
    output logic [sensio_pkg::CMD_DATA_BITS-1:0]  cmd_data_o
);
    import sensio_pkg::*;

    localparam int SR_BITS = 8 * CMD_BYTES;

    logic [CMD_CNT_BITS-1:0] byte_cnt; // 0 when idle
    logic [SR_BITS-1:0]      cmd_sr;   // first byte ends up lowest
    logic                    last_r;   // all bytes collected
    logic [15:0]             cmd_full_addr;
    logic                    addr_hit;

    always_ff @(posedge mclk) begin
        if (mclk_rst) begin
            byte_cnt <= '0;
        end else if (cmd_stb_i) begin
            byte_cnt <= CMD_CNT_BITS'(1); // new strobe restarts assembly
        end else if (byte_cnt != '0) begin
            if (byte_cnt == CMD_CNT_BITS'(CMD_BYTES - 1))
                byte_cnt <= '0;
            else
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (mclk_rst)
            last_r <= 1'b0;
        else
            last_r <= !cmd_stb_i && (byte_cnt == CMD_CNT_BITS'(CMD_BYTES - 1));
    end

    // shift in every byte of an active command
    always_ff @(posedge mclk) begin
        if (cmd_stb_i || (byte_cnt != '0))
            cmd_sr <= {cmd_ad_i, cmd_sr[SR_BITS-1:8]};
    end

    assign cmd_full_addr = cmd_sr[15:0];
    assign addr_hit      = ((cmd_full_addr ^ SENSIO_ADDR) & SENSIO_ADDR_MASK) == 16'h0000;

    assign cmd_we_o   = last_r && addr_hit; // one cycle, foreign blocks ignored
    assign cmd_addr_o = cmd_full_addr[CMD_ADDR_BITS-1:0];
    assign cmd_data_o = cmd_sr[SR_BITS-1 -: CMD_DATA_BITS];

endmodule

// File: logic/sensio_regs.sv
/* sensor i/o register file */
`timescale 1ns/1ps

module sensio_regs (
    input  logic                                   mclk,
    input  logic                                   mclk_rst,
    input  logic                                   cmd_we_i,
    input  logic [sensio_pkg::CMD_ADDR_BITS-1:0]   cmd_addr_i,
    input  logic [sensio_pkg::CMD_DATA_BITS-1:0]   cmd_data_i,
    sens_ctrl_if.regs                              ctrl_o,
    output logic [sensio_pkg::LINE_WIDTH_BITS-1:0] line_width_m1_o, // width - 1
    output logic                                   line_internal_o  // regenerate hact
);
    import sensio_pkg::*;

    sensio_data_u data_r;      // last accepted data word
    logic         set_ctrl_r;
    logic         set_jtag_r;
    logic [1:0]   set_width_r; // subtract gets its own cycle

    always_ff @(posedge mclk) begin
        if (cmd_we_i)
            data_r.raw <= cmd_data_i;
    end

    always_ff @(posedge mclk) begin
        if (mclk_rst) begin
            set_ctrl_r  <= 1'b0;
            set_jtag_r  <= 1'b0;
            set_width_r <= 2'b00;
        end else begin
            set_ctrl_r  <= cmd_we_i && (cmd_addr_i == SENSIO_CTRL);
            set_jtag_r  <= cmd_we_i && (cmd_addr_i == SENSIO_JTAG);
            set_width_r <= {set_width_r[0], cmd_we_i && (cmd_addr_i == SENSIO_WIDTH)};
        end
    end

    // sensor reset and aro pins
    always_ff @(posedge mclk) begin
        if (mclk_rst) begin
            ctrl_o.mrst     <= 1'b0;
            ctrl_o.arst     <= 1'b0;
            ctrl_o.aro_soft <= 1'b0;
        end else if (set_ctrl_r) begin
            ctrl_o.mrst     <= pair_next(ctrl_o.mrst, data_r.ctrl.mrst);
            ctrl_o.arst     <= pair_next(ctrl_o.arst, data_r.ctrl.arst);
            ctrl_o.aro_soft <= pair_next(ctrl_o.aro_soft, data_r.ctrl.aro);
        end
    end

    // jtag lines to the board fpga
    always_ff @(posedge mclk) begin
        if (mclk_rst) begin
            ctrl_o.pgmen <= 1'b0;
            ctrl_o.prog  <= 1'b0;
            ctrl_o.tck   <= 1'b0;
            ctrl_o.tms   <= 1'b0;
            ctrl_o.tdi   <= 1'b0;
        end else if (set_jtag_r) begin
            ctrl_o.pgmen <= pair_next(ctrl_o.pgmen, data_r.jtag.pgmen);
            ctrl_o.prog  <= pair_next(ctrl_o.prog, data_r.jtag.prog);
            ctrl_o.tck   <= pair_next(ctrl_o.tck, data_r.jtag.tck);
            ctrl_o.tms   <= pair_next(ctrl_o.tms, data_r.jtag.tms);
            ctrl_o.tdi   <= pair_next(ctrl_o.tdi, data_r.jtag.tdi);
        end
    end

    // line width, stored minus one for the hact down-counter
    always_ff @(posedge mclk) begin
        if (mclk_rst) begin
            line_width_m1_o <= '0;
            line_internal_o <= 1'b0;
        end else if (set_width_r[1]) begin
            line_width_m1_o <= data_r.raw[LINE_WIDTH_BITS-1:0] - 1'b1;
            line_internal_o <= |data_r.raw[LINE_WIDTH_BITS-1:0]; // 0 means pass hact
        end
    end

endmodule

// File: logic/sens_pin_ctrl.sv
/* sensor pin multiplexer */
`timescale 1ns/1ps

module sens_pin_ctrl (
    input  logic      mclk,
    input  logic      mclk_rst,
    sens_ctrl_if.pins ctrl_i,
    input  logic      trigger_mode_i, // 0 is free running
    input  logic      trig_i,
    input  logic      senspgm_i,      // senspgm pin level
    output logic      aro_o,          // aro or tck
    output logic      arst_o,         // arst or tms
    output logic      mrst_o,
    output logic      mrst_oe_o,      // off while done is read back
    output logic      senspgm_o,
    output logic      senspgm_oe_o,
    output logic      tdi_o,          // pxd0 in programming mode
    output logic      tdi_oe_o
);

    logic [1:0] pgmen_d;       // pgmen delay line for edge detect
    logic       force_senspgm; // level seen when programming ended
    logic       mrst_drv_en;   // mrst pin stays released until reset is over
    logic       aro_run;

    always_ff @(posedge mclk) begin
        if (mclk_rst) begin
            pgmen_d       <= 2'b00;
            force_senspgm <= 1'b0;
            mrst_drv_en   <= 1'b0;
        end else begin
            pgmen_d     <= {pgmen_d[0], ctrl_i.pgmen};
            mrst_drv_en <= 1'b1;
            if (pgmen_d == 2'b10) // pgmen just fell
                force_senspgm <= senspgm_i;
        end
    end

    assign aro_run = trigger_mode_i ? ~trig_i : ctrl_i.aro_soft;

    assign aro_o  = ctrl_i.pgmen ? ctrl_i.tck : aro_run;
    assign arst_o = ctrl_i.pgmen ? ctrl_i.tms : ctrl_i.arst;

    assign mrst_o    = ctrl_i.mrst;
    assign mrst_oe_o = mrst_drv_en && !ctrl_i.pgmen;

    assign tdi_o    = ctrl_i.tdi;
    assign tdi_oe_o = ctrl_i.pgmen;

    assign senspgm_o    = ctrl_i.pgmen ? ~ctrl_i.prog : force_senspgm;
    assign senspgm_oe_o = ctrl_i.pgmen || force_senspgm;

endmodule

// File: logic/hact_regen.sv
/* hact regenerator */
`timescale 1ns/1ps

module hact_regen (
    input  logic                                   mclk,
    input  logic                                   mclk_rst,
    input  logic                                   hact_i,
    input  logic [sensio_pkg::LINE_WIDTH_BITS-1:0] line_width_m1_i,
    input  logic                                   line_internal_i,
    output logic                                   hact_o
);
    import sensio_pkg::*;

    logic                       hact_d;    // hact_i one cycle back
    logic                       hact_rise;
    logic [LINE_WIDTH_BITS-1:0] hact_cnt;  // cycles left in the line
    logic                       hact_end;

    assign hact_rise = hact_i && !hact_d;
    assign hact_end  = line_internal_i ? (hact_cnt == '0) : !hact_i;

    always_ff @(posedge mclk) begin
        if (mclk_rst) begin
            hact_d <= 1'b0;
            hact_o <= 1'b0;
        end else begin
            hact_d <= hact_i;
            if (hact_rise)
                hact_o <= 1'b1;
            else if (hact_end)
                hact_o <= 1'b0;
        end
    end

    always_ff @(posedge mclk) begin
        if (mclk_rst)
            hact_cnt <= '0;
        else if (hact_rise)
            hact_cnt <= line_width_m1_i;  // w - 1 more cycles after the first
        else if (hact_o)
            hact_cnt <= hact_cnt - 1'b1;
    end

endmodule

// File: logic/sens_io_top.sv
/* sensor port control core */
`timescale 1ns/1ps

module sens_io_top (
    input  logic       mclk,
    input  logic       mclk_rst,
    input  logic [7:0] cmd_ad_i,       // byte-serial command
    input  logic       cmd_stb_i,
    input  logic       trigger_mode_i,
    input  logic       trig_i,
    input  logic       senspgm_i,
    input  logic       hact_i,
    output logic       aro_o,
    output logic       arst_o,
    output logic       mrst_o,
    output logic       mrst_oe_o,
    output logic       senspgm_o,
    output logic       senspgm_oe_o,
    output logic       tdi_o,          // pxd0
    output logic       tdi_oe_o,
    output logic       hact_o
);
    import sensio_pkg::*;

    logic                       cmd_we;
    logic [CMD_ADDR_BITS-1:0]   cmd_addr;
    logic [CMD_DATA_BITS-1:0]   cmd_data;
    logic [LINE_WIDTH_BITS-1:0] line_width_m1;
    logic                       line_internal;

    sens_ctrl_if i_ctrl_bus ();

    sensio_cmd_deser i_cmd_deser (
        .mclk       (mclk),
        .mclk_rst   (mclk_rst),
        .cmd_ad_i   (cmd_ad_i),
        .cmd_stb_i  (cmd_stb_i),
        .cmd_we_o   (cmd_we),
        .cmd_addr_o (cmd_addr),
        .cmd_data_o (cmd_data)
    );

    sensio_regs i_regs (
        .mclk            (mclk),
        .mclk_rst        (mclk_rst),
        .cmd_we_i        (cmd_we),
        .cmd_addr_i      (cmd_addr),
        .cmd_data_i      (cmd_data),
        .ctrl_o          (i_ctrl_bus.regs),
        .line_width_m1_o (line_width_m1),
        .line_internal_o (line_internal)
    );

    sens_pin_ctrl i_pin_ctrl (
        .mclk           (mclk),
        .mclk_rst       (mclk_rst),
        .ctrl_i         (i_ctrl_bus.pins),
        .trigger_mode_i (trigger_mode_i),
        .trig_i         (trig_i),
        .senspgm_i      (senspgm_i),
        .aro_o          (aro_o),
        .arst_o         (arst_o),
        .mrst_o         (mrst_o),
        .mrst_oe_o      (mrst_oe_o),
        .senspgm_o      (senspgm_o),
        .senspgm_oe_o   (senspgm_oe_o),
        .tdi_o          (tdi_o),
        .tdi_oe_o       (tdi_oe_o)
    );

    hact_regen i_hact_regen (
        .mclk            (mclk),
        .mclk_rst        (mclk_rst),
        .hact_i          (hact_i),
        .line_width_m1_i (line_width_m1),
        .line_internal_i (line_internal),
        .hact_o          (hact_o)
    );

endmodule

// File: test/tb_clk_gen.sv
/* testbench clock and reset */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic mclk_o,
    output logic mclk_rst_o
);

    localparam time HALF_PERIOD = 5ns; // 10 ns mclk
    localparam int  RST_CYCLES  = 4;

    initial begin
        mclk_o = 1'b0;
        forever #(HALF_PERIOD) mclk_o = ~mclk_o;
    end

    initial begin
        mclk_rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge mclk_o);
        @(negedge mclk_o);
        mclk_rst_o = 1'b0; // released between edges
    end

endmodule

// File: test/sens_io_assertions.sv
/* pin enable checks */
`timescale 1ns/1ps

module sens_io_assertions (
    input logic mclk,
    input logic mclk_rst,
    input logic mrst_oe_i,
    input logic tdi_oe_i,
    input logic senspgm_oe_i
);

    int fail_cnt = 0; // watched by the testbench

    // mrst and pxd0 share the board fpga lines, never driven together
    oe_exclusive: assert property (@(posedge mclk) disable iff (mclk_rst)
        !(mrst_oe_i && tdi_oe_i))
    else begin
        $error("mrst and pxd0 output enables are both high");
        fail_cnt++;
    end

    // second reset cycle on, registers are cleared by then
    rst_mrst_off: assert property (@(posedge mclk)
        (mclk_rst ##1 mclk_rst) |-> !mrst_oe_i)
    else begin
        $error("mrst output enable is high during reset");
        fail_cnt++;
    end

    rst_tdi_off: assert property (@(posedge mclk)
        (mclk_rst ##1 mclk_rst) |-> !tdi_oe_i)
    else begin
        $error("pxd0 output enable is high during reset");
        fail_cnt++;
    end

    rst_senspgm_off: assert property (@(posedge mclk)
        (mclk_rst ##1 mclk_rst) |-> !senspgm_oe_i)
    else begin
        $error("senspgm output enable is high during reset");
        fail_cnt++;
    end

endmodule

bind sens_pin_ctrl sens_io_assertions i_pin_checks (
    .mclk         (mclk),
    .mclk_rst     (mclk_rst),
    .mrst_oe_i    (mrst_oe_o),
    .tdi_oe_i     (tdi_oe_o),
    .senspgm_oe_i (senspgm_oe_o)
);

// File: test/tb_sens_io.sv
/* sensor port control testbench */
`timescale 1ns/1ps

module tb_sens_io;

    localparam int N_ENTRIES   = 14;
    localparam int IDLE_CYCLES = 12;
    localparam int CTRL_CYCLE  = 8;                      // pins take new values here
    localparam int HACT_WINDOW = 16;                     // cycles watched per pulse
    localparam int HACT_CYCLES = 3 * 20 + 5 * 20;        // width writes and pulses
    localparam int MAX_CYCLES  = N_ENTRIES * 20 + HACT_CYCLES;

    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] rnd_mask; // bits taken from the lfsr
        logic [2:0]  trig_set; // trigger_mode, trig, senspgm_i
        logic [7:0]  exp_pins; // aro arst mrst mrst_oe tdi tdi_oe senspgm senspgm_oe
    } entry_t;

    logic        mclk;
    logic        mclk_rst;
    logic [7:0]  cmd_ad_i;
    logic        cmd_stb_i;
    logic        trigger_mode_i;
    logic        trig_i;
    logic        senspgm_i;
    logic        hact_i;
    logic        aro_o;
    logic        arst_o;
    logic        mrst_o;
    logic        mrst_oe_o;
    logic        senspgm_o;
    logic        senspgm_oe_o;
    logic        tdi_o;
    logic        tdi_oe_o;
    logic        hact_o;

    entry_t      stim [N_ENTRIES];
    logic [15:0] lfsr_state;
    int          cycle_cnt   = 0;

    tb_clk_gen i_clk_gen (
        .mclk_o     (mclk),
        .mclk_rst_o (mclk_rst)
    );

    sens_io_top i_sens_io_top (
        .mclk           (mclk),
        .mclk_rst       (mclk_rst),
        .cmd_ad_i       (cmd_ad_i),
        .cmd_stb_i      (cmd_stb_i),
        .trigger_mode_i (trigger_mode_i),
        .trig_i         (trig_i),
        .senspgm_i      (senspgm_i),
        .hact_i         (hact_i),
        .aro_o          (aro_o),
        .arst_o         (arst_o),
        .mrst_o         (mrst_o),
        .mrst_oe_o      (mrst_oe_o),
        .senspgm_o      (senspgm_o),
        .senspgm_oe_o   (senspgm_oe_o),
        .tdi_o          (tdi_o),
        .tdi_oe_o       (tdi_oe_o),
        .hact_o         (hact_o)
    );

    // 16-bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic rand_word(output logic [31:0] w);
        int i;
        for (i = 0; i < 32; i++) begin
            w[i]       = lfsr_state[0]; // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else fail_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // resets and aro pins, already final in cycle 8
    task automatic check_reset_pins(input logic [7:0] exp);
        check_bit("aro_o", aro_o, exp[7]);
        check_bit("arst_o", arst_o, exp[6]);
        check_bit("mrst_o", mrst_o, exp[5]);
    endtask

    task automatic check_pins(input logic [7:0] exp);
        check_bit("aro_o", aro_o, exp[7]);
        check_bit("arst_o", arst_o, exp[6]);
        check_bit("mrst_o", mrst_o, exp[5]);
        check_bit("mrst_oe_o", mrst_oe_o, exp[4]);
        check_bit("tdi_o", tdi_o, exp[3]);
        check_bit("tdi_oe_o", tdi_oe_o, exp[2]);
        check_bit("senspgm_o", senspgm_o, exp[1]);
        check_bit("senspgm_oe_o", senspgm_oe_o, exp[0]);
    endtask

    // al, ah, d0..d3 on consecutive cycles, returns in cycle 8
    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        int          i;
        bytes = {data, addr};
        for (i = 0; i < 6; i++) begin
            @(negedge mclk);
            cmd_stb_i = (i == 0);
            cmd_ad_i  = bytes[8*i +: 8];
        end
        @(negedge mclk);
        cmd_ad_i = 8'h00;
        repeat (CTRL_CYCLE - 6) @(negedge mclk);
    endtask

    // rest of the idle gap after a command
    task automatic idle_rest();
        repeat (IDLE_CYCLES + 5 - CTRL_CYCLE) @(negedge mclk);
    endtask

    // hact_i high for hi_len cycles, hact_o expected high for exp_len
    task automatic run_pulse(input int hi_len, input int exp_len);
        int i;
        @(negedge mclk);
        hact_i = 1'b1;
        for (i = 1; i <= HACT_WINDOW; i++) begin
            @(negedge mclk);
            check_bit("hact_o", hact_o, i <= exp_len);
            hact_i = (i < hi_len);
        end
    endtask

    task automatic load_table();
        //          addr      data           rnd mask       trig    expected
        stim[0]  = {16'h0330, 32'h0000_0003, 32'hffff_ffd4, 3'b000, 8'b0011_0000};
        stim[1]  = {16'h0330, 32'h0000_003c, 32'hffff_ffc1, 3'b000, 8'b1111_0000};
        stim[2]  = {16'h0330, 32'h0000_0022, 32'hffff_ffc4, 3'b000, 8'b0101_0000};
        stim[3]  = {16'h0338, 32'h0000_003f, 32'hffff_ffc0, 3'b000, 8'b0101_0000}; // bit 3 off
        stim[4]  = {16'h0730, 32'h0000_0003, 32'hffff_ffc0, 3'b000, 8'b0101_0000}; // bit 10 off
        stim[5]  = {16'hf330, 32'h0000_0003, 32'hffff_ffd4, 3'b000, 8'b0111_0000}; // unmasked
        stim[6]  = {16'h0330, 32'h0000_0000, 32'hffff_ffd5, 3'b100, 8'b1111_0000};
        stim[7]  = {16'h0330, 32'h0000_0000, 32'hffff_ffd5, 3'b110, 8'b0111_0000};
        stim[8]  = {16'h0332, 32'h0000_03fb, 32'hffff_fc00, 3'b111, 8'b1010_1101};
        stim[9]  = {16'h0332, 32'h0000_00ae, 32'hffff_fd00, 3'b001, 8'b0110_0111};
        stim[10] = {16'h0332, 32'h0000_0200, 32'hffff_fc55, 3'b001, 8'b0111_0011};
        stim[11] = {16'h0332, 32'h0000_0300, 32'hffff_fc55, 3'b000, 8'b0110_0111};
        stim[12] = {16'h0332, 32'h0000_0200, 32'hffff_fc55, 3'b000, 8'b0111_0000};
        stim[13] = {16'h0330, 32'h0000_002a, 32'hffff_ffc0, 3'b001, 8'b0001_0000}; // probe holds
    endtask

    always @(posedge mclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
            fail_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end

    always @(negedge mclk) begin
        if (i_sens_io_top.i_pin_ctrl.i_pin_checks.fail_cnt != 0)
            fail_run("a concurrent assertion on the pin enables failed");
    end

    initial begin
        entry_t      e;
        logic [31:0] rnd;
        int          k;
        cmd_ad_i       = 8'h00;
        cmd_stb_i      = 1'b0;
        trigger_mode_i = 1'b0;
        trig_i         = 1'b0;
        senspgm_i      = 1'b0;
        hact_i         = 1'b0;
        lfsr_state     = 16'd3828;
        load_table();
        @(negedge mclk);
        while (mclk_rst)
            @(negedge mclk);

        for (k = 0; k < N_ENTRIES; k++) begin
            e = stim[k];
            rand_word(rnd);
            @(negedge mclk);
            {trigger_mode_i, trig_i, senspgm_i} = e.trig_set;
            send_cmd(e.addr, (e.data & ~e.rnd_mask) | (rnd & e.rnd_mask));
            check_reset_pins(e.exp_pins);
            idle_rest();
            check_pins(e.exp_pins);
        end

        // internal line width
        rand_word(rnd);
        send_cmd(16'h0333, {rnd[31:16], 16'd5});
        idle_rest();
        run_pulse(8, 5);
        run_pulse(3, 5);
        rand_word(rnd);
        send_cmd(16'h0333, {rnd[31:16], 16'd1});
        idle_rest();
        run_pulse(4, 1);
        rand_word(rnd);
        send_cmd(16'h0333, {rnd[31:16], 16'd0}); // back to pass-through
        idle_rest();
        run_pulse(6, 6);
        run_pulse(2, 2);

        if (i_sens_io_top.i_pin_ctrl.i_pin_checks.fail_cnt == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run("a concurrent assertion on the pin enables failed");
        end
    end

endmodule

// File: src.f
logic/sensio_pkg.sv
logic/sens_ctrl_if.sv
logic/sensio_cmd_deser.sv
logic/sensio_regs.sv
logic/sens_pin_ctrl.sv
logic/hact_regen.sv
logic/sens_io_top.sv
test/tb_clk_gen.sv
test/sens_io_assertions.sv
test/tb_sens_io.sv
